// ==== classifier_config.svh ====
`ifndef CLASSIFIER_CONFIG_SVH
`define CLASSIFIER_CONFIG_SVH

`default_nettype none

// Number of stream ids tracked by the design
`define NUM_STREAMS 64
// Stream id width
`define STREAM_W 6

// Matched prefix length per matcher
`define STATE_W 11
// Packet counter width, wraps on overflow
`define COUNT_W 16

// Number of keyword categories
`define NUM_CAT 2

`default_nettype wire

`endif

// ==== classifier_pkg.sv ====
`include "classifier_config.svh"

`default_nettype none

package classifier_pkg;

   // Stream id carried with each packet
   typedef logic [`STREAM_W-1:0] stream_id_t;

   // One payload byte
   typedef logic [7:0] byte_t;

   // Number of keyword bytes matched so far
   typedef logic [`STATE_W-1:0] match_state_t;

   // Per-category packet count
   typedef logic [`COUNT_W-1:0] count_t;

   // One enable bit per category
   typedef logic [`NUM_CAT-1:0] cat_mask_t;

endpackage

`default_nettype wire

// ==== stream_if.sv ====
`timescale 1ns/1ps

`default_nettype none

interface stream_if;
   import classifier_pkg::*;

   // Start of packet, one cycle
   logic       load_state;
   // Stream id of the current packet, held between sops
   stream_id_t stream_id;
   // First packet of this stream since reset
   logic       new_stream_id;
   // Byte stream
   byte_t      char;
   logic       char_vld;
   // End of packet, one cycle
   logic       eop;
   // Category enables for the stream, valid with eop
   cat_mask_t  enable;

   // Sequencer side
   modport src (
      output load_state, stream_id, new_stream_id, char, char_vld, eop, enable
   );

   // Category side
   modport dst (
      input load_state, stream_id, new_stream_id, char, char_vld, eop, enable
   );

endinterface

`default_nettype wire

// ==== stream_sequencer.sv ====
`timescale 1ns/1ps

`include "classifier_config.svh"

`default_nettype none

module stream_sequencer (
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire                             sop,
   input  wire classifier_pkg::stream_id_t sop_stream,
   input  wire classifier_pkg::byte_t      char,
   input  wire                             char_vld,
   input  wire                             eop,
   input  wire                             cfg_we,
   input  wire classifier_pkg::stream_id_t cfg_stream,
   input  wire classifier_pkg::cat_mask_t  cfg_mask,
   stream_if.src                           bus
);
   import classifier_pkg::*;

   // One bit per stream id, set on its first sop
   logic [`NUM_STREAMS-1:0] seen;

   // Category enable mask per stream id
   cat_mask_t mask_tbl [`NUM_STREAMS];

   // Seen table and mask table
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen <= '0;
         // All categories start disabled
         for (int i = 0; i < `NUM_STREAMS; i++)
         begin
            mask_tbl[i] <= '0;
         end
      end
      else
      begin
         // Stream becomes known once its first packet starts
         if (sop)
         begin
            seen[sop_stream] <= 1'b1;
         end
         // Config writes only happen between packets
         if (cfg_we)
         begin
            mask_tbl[cfg_stream] <= cfg_mask;
         end
      end
   end

   // Registered control strobes onto the stream bus
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         bus.load_state    <= 1'b0;
         bus.new_stream_id <= 1'b0;
         bus.char_vld      <= 1'b0;
         bus.eop           <= 1'b0;
         bus.stream_id     <= '0;
         bus.enable        <= '0;
      end
      else
      begin
         bus.load_state <= sop;
         // Seen bit is read before this sop sets it
         bus.new_stream_id <= sop & ~seen[sop_stream];
         bus.char_vld      <= char_vld;
         bus.eop           <= eop;

         // Stream id stays put for the whole packet
         if (sop)
         begin
            bus.stream_id <= sop_stream;
         end

         // Held stream id already belongs to this packet when eop arrives
         if (eop)
         begin
            bus.enable <= mask_tbl[bus.stream_id];
         end
         else
         begin
            bus.enable <= '0;
         end
      end
   end

   // Byte payload, qualified by char_vld
   always_ff @(posedge clk)
   begin
      bus.char <= char;
   end

endmodule

`default_nettype wire

// ==== keyword_matcher.sv ====
`timescale 1ns/1ps

`default_nettype none

module keyword_matcher #(
   parameter logic [8*16-1:0] KEYWORD = "freenet"
) (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire classifier_pkg::byte_t        char,
   input  wire                               char_vld,
   input  wire classifier_pkg::match_state_t state_in,
   input  wire                               state_in_vld,
   output classifier_pkg::match_state_t      state_out,
   output logic                              accept
);
   import classifier_pkg::*;

   // Keyword string is right aligned, leading zero bytes are padding
   function automatic int kw_length(input logic [$bits(KEYWORD)-1:0] kw);
      int len;
      len = 0;
      for (int i = 0; i < $bits(KEYWORD) / 8; i++)
      begin
         if (kw[8*i +: 8] != 8'h00)
         begin
            len = i + 1;
         end
      end
      return len;
   endfunction

   localparam int           KW_LEN = kw_length(KEYWORD);
   localparam match_state_t FULL   = match_state_t'(KW_LEN);

   // Keyword byte at position idx, first character is position 0
   function automatic byte_t kw_byte(input match_state_t idx);
      byte_t b;
      b = '0;
      for (int i = 0; i < KW_LEN; i++)
      begin
         if (match_state_t'(i) == idx)
         begin
            b = KEYWORD[8*(KW_LEN-1-i) +: 8];
         end
      end
      return b;
   endfunction

   match_state_t cur_state;
   match_state_t next_state;

   // Loaded state takes effect before the byte of the same cycle
   always_comb
   begin
      cur_state = state_in_vld ? state_in : state_out;
      if (cur_state < FULL && char == kw_byte(cur_state))
         next_state = cur_state + 1'b1;
      else if (char == kw_byte('0))
         next_state = match_state_t'(1);    // restart on the first character
      else
         next_state = '0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out <= '0;
         accept    <= 1'b0;
      end
      else
      begin
         accept <= 1'b0;
         if (char_vld)
         begin
            // Full keyword seen, pulse accept and start over
            if (next_state == FULL)
            begin
               state_out <= '0;
               accept    <= 1'b1;
            end
            else
            begin
               state_out <= next_state;
            end
         end
         else if (state_in_vld)
         begin
            state_out <= state_in;
         end
      end
   end

endmodule

`default_nettype wire

// ==== category_counter.sv ====
`timescale 1ns/1ps

`include "classifier_config.svh"

`default_nettype none

module category_counter #(
   parameter int CAT     = 0,
   parameter     KEYWORD = "freenet"
) (
   input  wire                     clk,
   input  wire                     rst_n,
   stream_if.dst                   bus,
   output classifier_pkg::count_t  count,
   output logic                    fired
);
   import classifier_pkg::*;

   // Saved matcher state per stream id
   match_state_t state_mem [`NUM_STREAMS];

   // State handed to the matcher one cycle after load_state
   match_state_t state_in;
   logic         state_in_vld;

   match_state_t state_out;
   logic         accept;

   // An empty packet ends before the restored state reaches the matcher
   match_state_t save_state;

   // Keyword seen somewhere in the current packet
   logic spec_match;
   // Includes an accept landing on the eop cycle
   logic pkt_hit;

   assign pkt_hit    = spec_match | accept;
   assign fired      = spec_match;
   assign save_state = state_in_vld ? state_in : state_out;

   keyword_matcher #(
      .KEYWORD (KEYWORD)
   ) u_matcher (
      .clk          (clk),
      .rst_n        (rst_n),
      .char         (bus.char),
      .char_vld     (bus.char_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept       (accept)
   );

   // Restore strobe follows load_state by one cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= bus.load_state;
   end

   // New streams start from zero and known ones resume
   always_ff @(posedge clk)
   begin
      if (bus.load_state)
      begin
         state_in <= bus.new_stream_id ? '0 : state_mem[bus.stream_id];
      end
   end

   // Save state only when the category is enabled for this stream
   always_ff @(posedge clk)
   begin
      if (bus.eop && bus.enable[CAT])
      begin
         state_mem[bus.stream_id] <= save_state;
      end
   end

   // Match flag and packet count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count      <= '0;
         spec_match <= 1'b0;
      end
      else
      begin
         // Fresh packet clears the flag
         if (bus.load_state)
            spec_match <= 1'b0;
         if (accept)
            spec_match <= 1'b1;

         if (bus.eop)
         begin
            if (bus.enable[CAT])
            begin
               // Counts once per packet and wraps at the top
               count <= count + count_t'(pkt_hit);
            end
            else
            begin
               // Disabled category drops the match
               spec_match <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== regex_classifier.sv ====
`timescale 1ns/1ps

`include "classifier_config.svh"

`default_nettype none

module regex_classifier (
   input  wire                                        clk,
   input  wire                                        rst_n,
   input  wire                                        sop,
   input  wire classifier_pkg::stream_id_t            sop_stream,
   input  wire classifier_pkg::byte_t                 char,
   input  wire                                        char_vld,
   input  wire                                        eop,
   input  wire                                        cfg_we,
   input  wire classifier_pkg::stream_id_t            cfg_stream,
   input  wire classifier_pkg::cat_mask_t             cfg_mask,
   output wire classifier_pkg::count_t [`NUM_CAT-1:0] count,
   output wire classifier_pkg::cat_mask_t             fired
);
   import classifier_pkg::*;

   // Keyword per category, category index order
   localparam logic [8*16-1:0] KEYWORDS [`NUM_CAT] = '{"freenet", "gnutella"};

   // Shared control and byte stream
   stream_if bus ();

   stream_sequencer u_seq (
      .clk        (clk),
      .rst_n      (rst_n),
      .sop        (sop),
      .sop_stream (sop_stream),
      .char       (char),
      .char_vld   (char_vld),
      .eop        (eop),
      .cfg_we     (cfg_we),
      .cfg_stream (cfg_stream),
      .cfg_mask   (cfg_mask),
      .bus        (bus)
   );

   // One counter per category, all listening to the same stream
   for (genvar g = 0; g < `NUM_CAT; g++)
   begin : gen_cat
      category_counter #(
         .CAT     (g),
         .KEYWORD (KEYWORDS[g])
      ) u_cat (
         .clk   (clk),
         .rst_n (rst_n),
         .bus   (bus),
         .count (count[g]),
         .fired (fired[g])
      );
   end

endmodule

`default_nettype wire

// ==== classifier_assert.sv ====
`timescale 1ns/1ps

`default_nettype none

module classifier_assert (
   input wire clk,
   input wire rst_n,
   input wire load_state,
   input wire new_stream_id,
   input wire char_vld,
   input wire eop
);

   // Failures seen so far
   int assert_errs = 0;

   // Start of packet lasts one cycle
   load_state_pulse: assert property (
      @(posedge clk) disable iff (!rst_n) load_state |=> !load_state
   )
   else
   begin
      assert_errs++;
      $error("load_state held high for more than one cycle");
   end

   // A byte never shares its cycle with the end of packet
   byte_eop_apart: assert property (
      @(posedge clk) disable iff (!rst_n) !(char_vld && eop)
   )
   else
   begin
      assert_errs++;
      $error("char_vld and eop high in the same cycle");
   end

   // Synchronous reset clears every strobe one edge later
   strobes_in_reset: assert property (
      @(posedge clk) !rst_n |=> !load_state && !new_stream_id && !char_vld && !eop
   )
   else
   begin
      assert_errs++;
      $error("stream bus strobe high during reset");
   end

endmodule

// Watch the bus where the sequencer drives it
bind stream_sequencer classifier_assert u_assert (
   .clk           (clk),
   .rst_n         (rst_n),
   .load_state    (bus.load_state),
   .new_stream_id (bus.new_stream_id),
   .char_vld      (bus.char_vld),
   .eop           (bus.eop)
);

`default_nettype wire

// ==== tb_regex_classifier.sv ====
`timescale 1ns/1ps

`include "classifier_config.svh"

`default_nettype none

module tb_regex_classifier;
   import classifier_pkg::*;

   localparam int CLK_PERIOD    = 4;
   localparam int NUM_RAND_PKTS = 40;
   // Longest packet is 22 bytes with a possible gap before each
   // plus sop, eop, drain and a config write
   localparam int MAX_PKT_CYC   = 60;
   localparam int NUM_PKTS      = NUM_RAND_PKTS + 16;
   localparam int TIMEOUT_CYC   = NUM_PKTS * MAX_PKT_CYC + 16 * 2 + 200;

   logic                  clk;
   logic                  rst_n;
   logic                  sop;
   stream_id_t            sop_stream;
   byte_t                 char;
   logic                  char_vld;
   logic                  eop;
   logic                  cfg_we;
   stream_id_t            cfg_stream;
   cat_mask_t             cfg_mask;
   count_t [`NUM_CAT-1:0] count;
   cat_mask_t             fired;

   // Reference model keeps one saved prefix length per category and stream
   string     keywords [`NUM_CAT];
   int        saved [`NUM_CAT][`NUM_STREAMS];
   bit        seen_ref [`NUM_STREAMS];
   cat_mask_t mask_ref [`NUM_STREAMS];
   count_t    exp_count [`NUM_CAT];
   cat_mask_t exp_fired;

   // Expected values waiting for the compare process
   count_t    exp_count_q [$];
   cat_mask_t exp_fired_q [$];

   byte_t       pkt_buf [64];
   int          pkt_len;
   logic [31:0] lfsr;
   int          count_errs = 0;
   int          fired_errs = 0;
   int          checks = 0;
   count_t      cmp_count;
   cat_mask_t   cmp_fired;

   regex_classifier UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .sop        (sop),
      .sop_stream (sop_stream),
      .char       (char),
      .char_vld   (char_vld),
      .eop        (eop),
      .cfg_we     (cfg_we),
      .cfg_stream (cfg_stream),
      .cfg_mask   (cfg_mask),
      .count      (count),
      .fired      (fired)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v = (v << 1) | int'(lfsr[0]);
      end
      return v;
   endfunction

   // Restart rule of one matcher gives the new prefix length
   function automatic int match_step(input string kw, input int st, input byte_t ch);
      if (st < kw.len() && ch == kw[st])
         return st + 1;
      else if (ch == kw[0])
         return 1;
      return 0;
   endfunction

   task automatic push_expected();
      for (int c = 0; c < `NUM_CAT; c++)
         exp_count_q.push_back(exp_count[c]);
      exp_fired_q.push_back(exp_fired);
   endtask

   task automatic write_mask(input stream_id_t s, input cat_mask_t m);
      @(negedge clk);
      cfg_we     = 1'b1;
      cfg_stream = s;
      cfg_mask   = m;
      @(negedge clk);
      cfg_we     = 1'b0;
      mask_ref[s] = m;
   endtask

   task automatic add_text(input string t);
      for (int i = 0; i < t.len(); i++)
      begin
         pkt_buf[pkt_len] = t[i];
         pkt_len = pkt_len + 1;
      end
   endtask

   // Half the bytes come from the keyword letters to provoke partial matches
   task automatic add_random(input int n);
      int c;
      for (int i = 0; i < n; i++)
      begin
         c = rand_bits(1) % `NUM_CAT;
         if (rand_bits(1))
            pkt_buf[pkt_len] = keywords[c][rand_bits(3) % keywords[c].len()];
         else
            pkt_buf[pkt_len] = byte_t'(rand_bits(8));
         pkt_len = pkt_len + 1;
      end
   endtask

   // Mode 1 adds a whole keyword and modes 2 and 3 a head at the end or a tail at the start
   task automatic build_random();
      int    mode;
      int    k;
      string kw;
      pkt_len = 0;
      mode = rand_bits(2);
      kw   = keywords[rand_bits(1) % `NUM_CAT];
      k    = 1 + rand_bits(3) % (kw.len() - 1);
      if (mode != 3)
         add_random(rand_bits(3));
      if (mode == 1)
         add_text(kw);
      else if (mode == 2)
         add_text(kw.substr(0, k - 1));
      else if (mode == 3)
         add_text(kw.substr(k, kw.len() - 1));
      if (mode != 2)
         add_random(rand_bits(3));
   endtask

   // Sends pkt_buf on stream s and runs the reference model alongside
   task automatic send_packet(input stream_id_t s);
      int   st [`NUM_CAT];
      logic hit [`NUM_CAT];
      int   nxt;
      for (int c = 0; c < `NUM_CAT; c++)
      begin
         // Unseen stream starts from zero
         st[c]  = seen_ref[s] ? saved[c][s] : 0;
         hit[c] = 1'b0;
      end
      seen_ref[s] = 1'b1;
      @(negedge clk);
      sop        = 1'b1;
      sop_stream = s;
      @(negedge clk);
      sop = 1'b0;
      for (int i = 0; i < pkt_len; i++)
      begin
         // Occasional idle cycle between bytes
         if (rand_bits(2) == 0)
            @(negedge clk);
         char     = pkt_buf[i];
         char_vld = 1'b1;
         for (int c = 0; c < `NUM_CAT; c++)
         begin
            nxt = match_step(keywords[c], st[c], pkt_buf[i]);
            hit[c] = hit[c] | (nxt == keywords[c].len());
            st[c]  = (nxt == keywords[c].len()) ? 0 : nxt;
         end
         @(negedge clk);
         char_vld = 1'b0;
      end
      eop = 1'b1;
      @(negedge clk);
      eop = 1'b0;
      // Count and save only where the category is enabled
      for (int c = 0; c < `NUM_CAT; c++)
      begin
         exp_fired[c] = mask_ref[s][c] & hit[c];
         if (mask_ref[s][c])
         begin
            exp_count[c] = exp_count[c] + count_t'(hit[c]);
            saved[c][s]  = st[c];
         end
      end
      // Counts are settled three cycles after eop
      repeat (3) @(negedge clk);
      push_expected();
      @(negedge clk);
   endtask

   task automatic text_packet(input stream_id_t s, input string t);
      pkt_len = 0;
      add_text(t);
      send_packet(s);
   endtask

   // Compare at the falling edge where the outputs are stable
   always @(negedge clk)
   begin
      if (exp_fired_q.size() > 0)
      begin
         cmp_fired = exp_fired_q.pop_front();
         checks = checks + 1;
         for (int c = 0; c < `NUM_CAT; c++)
         begin
            cmp_count = exp_count_q.pop_front();
            if (count[c] !== cmp_count)
            begin
               $display("** Error: count[%0d] = 0x%h, expected 0x%h",
                        c, count[c], cmp_count);
               count_errs = count_errs + 1;
            end
         end
         if (fired !== cmp_fired)
         begin
            $display("** Error: fired = 0x%h, expected 0x%h", fired, cmp_fired);
            fired_errs = fired_errs + 1;
         end
      end
   end

   // Watchdog
   initial
   begin
      #(TIMEOUT_CYC * CLK_PERIOD);
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("test failed");
      $finish;
   end

   initial
   begin
      rst_n      = 1'b0;
      sop        = 1'b0;
      sop_stream = '0;
      char       = '0;
      char_vld   = 1'b0;
      eop        = 1'b0;
      cfg_we     = 1'b0;
      cfg_stream = '0;
      cfg_mask   = '0;
      lfsr       = 32'h2a6e_572f;
      keywords[0] = "freenet";
      keywords[1] = "gnutella";
      for (int s = 0; s < `NUM_STREAMS; s++)
      begin
         seen_ref[s] = 1'b0;
         mask_ref[s] = '0;
         for (int c = 0; c < `NUM_CAT; c++)
            saved[c][s] = 0;
      end
      for (int c = 0; c < `NUM_CAT; c++)
         exp_count[c] = '0;
      exp_fired = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // Everything reads zero out of reset
      push_expected();
      @(negedge clk);
      // First packet of every stream in use runs with all categories on
      for (int s = 0; s < 16; s++)
         write_mask(stream_id_t'(s), '1);

      // Keyword twice in one packet counts once
      text_packet(1, "xxfreenetyyfreenetz");
      // Restart on the first character with both categories in one packet
      text_packet(9, "ffreenetgnutgnutella");
      // Split over two packets of one stream
      text_packet(2, "abfree");
      text_packet(2, "netcd");
      // Same split spread over two streams
      text_packet(3, "zzgnut");
      text_packet(4, "ellazz");
      // Stale state of stream 7 stays out of the first packet of stream 8
      text_packet(7, "xfree");
      text_packet(8, "net");
      // Empty packet keeps the saved prefix of stream 7
      text_packet(7, "");
      text_packet(7, "net");
      // Disabled packet must not overwrite the saved prefix
      text_packet(5, "fre");
      write_mask(5, 2'b10);
      text_packet(5, "xfr");
      write_mask(5, '1);
      text_packet(5, "enet");
      // Disabled category never counts
      text_packet(6, "x");
      write_mask(6, 2'b01);
      text_packet(6, "gnutella");

      // Random packets over 16 interleaved streams
      for (int p = 0; p < NUM_RAND_PKTS; p++)
      begin
         sop_stream = stream_id_t'(rand_bits(4));
         if (seen_ref[sop_stream] && rand_bits(2) == 0)
            write_mask(sop_stream, cat_mask_t'(rand_bits(`NUM_CAT)));
         build_random();
         send_packet(sop_stream);
      end

      repeat (3) @(negedge clk);
      if (exp_fired_q.size() != 0)
      begin
         $display("Compare queue still holds %0d entries at the end", exp_fired_q.size());
         count_errs = count_errs + 1;
      end
      $display("Errors: count %0d, fired %0d, assertions %0d, in %0d checks",
               count_errs, fired_errs, UUT.u_seq.u_assert.assert_errs, checks);
      if (count_errs + fired_errs + UUT.u_seq.u_assert.assert_errs == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
classifier_pkg.sv
stream_if.sv
stream_sequencer.sv
keyword_matcher.sv
category_counter.sv
regex_classifier.sv
classifier_assert.sv
tb_regex_classifier.sv

// ==== Bender.yml ====
package:
  name: regex_classifier

sources:
  - include_dirs:
      - .
    files:
      - classifier_pkg.sv
      - stream_if.sv
      - stream_sequencer.sv
      - keyword_matcher.sv
      - category_counter.sv
      - regex_classifier.sv
  - target: test
    include_dirs:
      - .
    files:
      - classifier_assert.sv
      - tb_regex_classifier.sv
